//--- list.f
source/accel_pkg.sv
source/accel_regs.sv
source/desc_fifo.sv
source/pkt_rd_dma.sv
source/pattern_matcher.sv
source/ip_lookup.sv
source/accel_top.sv
tests/accel_checker.sv
tests/accel_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the accel testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module accel_tb -o accel_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/accel_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "SIMULATION PASSED"; then
  exit 0
fi
exit 1

//--- source/accel_pkg.sv
package accel_pkg;

  localparam int IO_ADDR_W = 8;
  localparam int IO_DATA_W = 32;
  localparam int LEN_W     = 8;
  localparam int RULE_ID_W = 8;

  // Control word bit positions
  localparam int CTRL_START   = 0;
  localparam int CTRL_RELEASE = 1;
  localparam int CTRL_STOP    = 2;

  // Host register map, byte offsets
  typedef enum logic [IO_ADDR_W-1:0] {
    REG_CTRL   = 8'h00,
    REG_LEN    = 8'h04,
    REG_ADDR   = 8'h08,
    REG_RULE   = 8'h0C,
    REG_SRC_IP = 8'h10,
    REG_IP_RES = 8'h14,
    REG_IP_TAB = 8'h40
  } reg_addr_e;

  typedef enum logic [1:0] {
    DMA_IDLE,
    DMA_READ,
    DMA_DRAIN
  } dma_state_e;

  typedef enum logic [1:0] {
    IP_IDLE,
    IP_SCAN,
    IP_DONE
  } ip_state_e;

endpackage

//--- source/accel_regs.sv
`timescale 1ns/1ps

module accel_regs #(
  parameter int MEM_ADDR_W = 10,
  parameter int IP_ENTRIES = 4
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              io_en,
  input  logic                              io_wen,
  input  logic [accel_pkg::IO_ADDR_W-1:0]   io_addr,
  input  logic [accel_pkg::IO_DATA_W-1:0]   io_wr_data,
  input  logic                              match_valid,
  input  logic                              match_found,
  input  logic [accel_pkg::RULE_ID_W-1:0]   rule_id,
  input  logic                              dma_busy,
  input  logic                              fifo_full,
  input  logic                              ip_match,
  input  logic                              ip_done,
  output logic [accel_pkg::IO_DATA_W-1:0]   io_rd_data,
  output logic                              io_rd_valid,
  output logic                              desc_push,
  output logic [MEM_ADDR_W-1:0]             desc_addr,
  output logic [accel_pkg::LEN_W-1:0]       desc_len,
  output logic                              match_release,
  output logic                              stop,
  output logic                              ip_valid,
  output logic [accel_pkg::IO_DATA_W-1:0]   src_ip,
  output logic                              tab_wr_en,
  output logic [$clog2(IP_ENTRIES)-1:0]     tab_wr_idx,
  output logic [accel_pkg::IO_DATA_W-1:0]   tab_wr_data
);
  import accel_pkg::*;

  localparam int IDX_W = $clog2(IP_ENTRIES);

  logic                 wr_strobe;
  logic                 rd_strobe;
  logic                 stall;
  logic                 ip_ready;
  logic                 tab_hit;
  logic [IO_ADDR_W-1:0] tab_off;
  logic [IO_DATA_W-1:0] rd_mux;

  assign wr_strobe = io_en && io_wen;
  assign rd_strobe = io_en && !io_wen;

  // Table entries are word aligned above REG_IP_TAB
  assign tab_off = io_addr - REG_IP_TAB;
  assign tab_hit = (io_addr >= REG_IP_TAB) && (tab_off[1:0] == 2'b00) &&
                   (tab_off[IO_ADDR_W-1:2] < IP_ENTRIES);

  // A pending ip_valid means done still belongs to the previous address
  assign ip_ready = ip_done && !ip_valid;

  always_comb begin
    rd_mux = '0;
    case (io_addr)
      REG_CTRL:   rd_mux[3:0] = {fifo_full, dma_busy, match_found, match_valid};
      REG_LEN:    rd_mux[LEN_W-1:0] = desc_len;
      REG_ADDR:   rd_mux[MEM_ADDR_W-1:0] = desc_addr;
      REG_RULE:   rd_mux[RULE_ID_W-1:0] = rule_id;
      REG_SRC_IP: rd_mux = src_ip;
      REG_IP_RES: rd_mux[0] = ip_match;
      default:    rd_mux = '0;
    endcase
  end

  // Strobes and read handshake
  always_ff @(posedge clk) begin
    if (rst) begin
      desc_push     <= 1'b0;
      match_release <= 1'b0;
      stop          <= 1'b0;
      ip_valid      <= 1'b0;
      tab_wr_en     <= 1'b0;
      io_rd_valid   <= 1'b0;
      stall         <= 1'b0;
    end else begin
      desc_push     <= wr_strobe && (io_addr == REG_CTRL) && io_wr_data[CTRL_START];
      match_release <= wr_strobe && (io_addr == REG_CTRL) && io_wr_data[CTRL_RELEASE];
      stop          <= wr_strobe && (io_addr == REG_CTRL) && io_wr_data[CTRL_STOP];
      ip_valid      <= wr_strobe && (io_addr == REG_SRC_IP);
      tab_wr_en     <= wr_strobe && tab_hit;
      io_rd_valid   <= 1'b0;
      if (rd_strobe) begin
        if ((io_addr == REG_IP_RES) && !ip_ready) begin
          stall <= 1'b1;
        end else begin
          io_rd_valid <= 1'b1;
        end
      end else if (stall && ip_ready) begin
        // Host keeps io_addr during the stall
        stall       <= 1'b0;
        io_rd_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_strobe) begin
      if (io_addr == REG_LEN) begin
        desc_len <= io_wr_data[LEN_W-1:0];
      end
      if (io_addr == REG_ADDR) begin
        desc_addr <= io_wr_data[MEM_ADDR_W-1:0];
      end
      if (io_addr == REG_SRC_IP) begin
        src_ip <= io_wr_data;
      end
      tab_wr_idx  <= tab_off[2 +: IDX_W];
      tab_wr_data <= io_wr_data;
    end
    if (rd_strobe || stall) begin
      io_rd_data <= rd_mux;
    end
  end

endmodule

//--- source/accel_top.sv
`timescale 1ns/1ps

module accel_top #(
  parameter int MEM_ADDR_W = 10,
  parameter int RULE_COUNT = 8,
  parameter int IP_ENTRIES = 4,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            io_en,
  input  logic                            io_wen,
  input  logic [accel_pkg::IO_ADDR_W-1:0] io_addr,
  input  logic [accel_pkg::IO_DATA_W-1:0] io_wr_data,
  output logic [accel_pkg::IO_DATA_W-1:0] io_rd_data,
  output logic                            io_rd_valid,
  input  logic                            rule_wr_en,
  input  logic [$clog2(RULE_COUNT)-1:0]   rule_wr_addr,
  input  logic [accel_pkg::IO_DATA_W-1:0] rule_wr_data,
  output logic                            mem_en,
  output logic [MEM_ADDR_W-1:0]           mem_addr,
  input  logic [accel_pkg::IO_DATA_W-1:0] mem_rd_data
);
  import accel_pkg::*;

  logic                          desc_push;
  logic [MEM_ADDR_W-1:0]         reg_addr;
  logic [LEN_W-1:0]              reg_len;
  logic                          match_release;
  logic                          stop;
  logic                          ip_valid;
  logic [IO_DATA_W-1:0]          src_ip;
  logic                          tab_wr_en;
  logic [$clog2(IP_ENTRIES)-1:0] tab_wr_idx;
  logic [IO_DATA_W-1:0]          tab_wr_data;
  logic                          fifo_empty;
  logic                          fifo_full;
  logic                          fifo_pop;
  logic [MEM_ADDR_W-1:0]         fifo_addr;
  logic [LEN_W-1:0]              fifo_len;
  logic                          word_valid;
  logic [IO_DATA_W-1:0]          word_data;
  logic                          word_last;
  logic                          abort;
  logic                          dma_busy;
  logic                          match_valid;
  logic                          match_found;
  logic [RULE_ID_W-1:0]          rule_id;
  logic                          ip_match;
  logic                          ip_done;

  accel_regs #(.MEM_ADDR_W(MEM_ADDR_W), .IP_ENTRIES(IP_ENTRIES)) regs0 (
    .clk(clk), .rst(rst), .io_en(io_en), .io_wen(io_wen), .io_addr(io_addr),
    .io_wr_data(io_wr_data), .match_valid(match_valid), .match_found(match_found),
    .rule_id(rule_id), .dma_busy(dma_busy), .fifo_full(fifo_full), .ip_match(ip_match),
    .ip_done(ip_done), .io_rd_data(io_rd_data), .io_rd_valid(io_rd_valid),
    .desc_push(desc_push), .desc_addr(reg_addr), .desc_len(reg_len),
    .match_release(match_release), .stop(stop), .ip_valid(ip_valid), .src_ip(src_ip),
    .tab_wr_en(tab_wr_en), .tab_wr_idx(tab_wr_idx), .tab_wr_data(tab_wr_data)
  );

  desc_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .MEM_ADDR_W(MEM_ADDR_W)) fifo0 (
    .clk(clk), .rst(rst), .push(desc_push), .push_addr(reg_addr), .push_len(reg_len),
    .pop(fifo_pop), .empty(fifo_empty), .full(fifo_full), .pop_addr(fifo_addr),
    .pop_len(fifo_len)
  );

  // A held match result stalls further descriptor pops
  pkt_rd_dma #(.MEM_ADDR_W(MEM_ADDR_W)) dma0 (
    .clk(clk), .rst(rst), .fifo_empty(fifo_empty), .desc_addr(fifo_addr),
    .desc_len(fifo_len), .hold(match_valid), .stop(stop), .mem_rd_data(mem_rd_data),
    .pop(fifo_pop), .mem_en(mem_en), .mem_addr(mem_addr), .word_valid(word_valid),
    .word_data(word_data), .word_last(word_last), .abort(abort), .busy(dma_busy)
  );

  pattern_matcher #(.RULE_COUNT(RULE_COUNT)) matcher0 (
    .clk(clk), .rst(rst), .rule_wr_en(rule_wr_en), .rule_wr_addr(rule_wr_addr),
    .rule_wr_data(rule_wr_data), .word_valid(word_valid), .word_data(word_data),
    .word_last(word_last), .abort(abort), .match_release(match_release),
    .match_valid(match_valid), .match_found(match_found), .rule_id(rule_id)
  );

  ip_lookup #(.IP_ENTRIES(IP_ENTRIES)) lookup0 (
    .clk(clk), .rst(rst), .tab_wr_en(tab_wr_en), .tab_wr_idx(tab_wr_idx),
    .tab_wr_data(tab_wr_data), .ip_valid(ip_valid), .src_ip(src_ip),
    .match(ip_match), .done(ip_done)
  );

endmodule

//--- source/desc_fifo.sv
`timescale 1ns/1ps

module desc_fifo #(
  parameter int FIFO_DEPTH = 4,
  parameter int MEM_ADDR_W = 10
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        push,
  input  logic [MEM_ADDR_W-1:0]       push_addr,
  input  logic [accel_pkg::LEN_W-1:0] push_len,
  input  logic                        pop,
  output logic                        empty,
  output logic                        full,
  output logic [MEM_ADDR_W-1:0]       pop_addr,
  output logic [accel_pkg::LEN_W-1:0] pop_len
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [MEM_ADDR_W-1:0]       addr_mem [FIFO_DEPTH];
  logic [accel_pkg::LEN_W-1:0] len_mem  [FIFO_DEPTH];
  logic [PTR_W-1:0]            wr_ptr;
  logic [PTR_W-1:0]            rd_ptr;
  logic [CNT_W-1:0]            count;
  logic                        push_ok;
  logic                        pop_ok;

  // Full pushes and empty pops are dropped
  assign push_ok  = push && !full;
  assign pop_ok   = pop && !empty;
  assign empty    = (count == '0);
  assign full     = (count == CNT_W'(FIFO_DEPTH));
  assign pop_addr = addr_mem[rd_ptr];
  assign pop_len  = len_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push_ok) - CNT_W'(pop_ok);
    end
  end

  always_ff @(posedge clk) begin
    if (push_ok) begin
      addr_mem[wr_ptr] <= push_addr;
      len_mem[wr_ptr]  <= push_len;
    end
  end

endmodule

//--- source/ip_lookup.sv
`timescale 1ns/1ps

module ip_lookup #(
  parameter int IP_ENTRIES = 4
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            tab_wr_en,
  input  logic [$clog2(IP_ENTRIES)-1:0]   tab_wr_idx,
  input  logic [accel_pkg::IO_DATA_W-1:0] tab_wr_data,
  input  logic                            ip_valid,
  input  logic [accel_pkg::IO_DATA_W-1:0] src_ip,
  output logic                            match,
  output logic                            done
);
  import accel_pkg::*;

  localparam int IDX_W = $clog2(IP_ENTRIES);

  logic [IO_DATA_W-1:0] ip_table [IP_ENTRIES];
  logic [IO_DATA_W-1:0] key;
  logic [IDX_W-1:0]     idx;
  logic                 hit;
  logic                 hit_acc;
  ip_state_e            state;

  assign hit  = (ip_table[idx] == key);
  assign done = (state == IP_DONE);

  always_ff @(posedge clk) begin
    if (tab_wr_en) begin
      ip_table[tab_wr_idx] <= tab_wr_data;
    end
    // Network byte order to host order
    if (ip_valid) begin
      key <= {src_ip[7:0], src_ip[15:8], src_ip[23:16], src_ip[31:24]};
    end
  end

  // One entry per cycle, result holds until the next ip_valid
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= IP_IDLE;
      match   <= 1'b0;
      hit_acc <= 1'b0;
      idx     <= '0;
    end else if (ip_valid) begin
      state   <= IP_SCAN;
      match   <= 1'b0;
      hit_acc <= 1'b0;
      idx     <= '0;
    end else if (state == IP_SCAN) begin
      hit_acc <= hit_acc | hit;
      idx     <= idx + 1'b1;
      if (idx == IDX_W'(IP_ENTRIES - 1)) begin
        state <= IP_DONE;
        match <= hit_acc | hit;
      end
    end
  end

endmodule

//--- source/pattern_matcher.sv
`timescale 1ns/1ps

module pattern_matcher #(
  parameter int RULE_COUNT = 8
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            rule_wr_en,
  input  logic [$clog2(RULE_COUNT)-1:0]   rule_wr_addr,
  input  logic [accel_pkg::IO_DATA_W-1:0] rule_wr_data,
  input  logic                            word_valid,
  input  logic [accel_pkg::IO_DATA_W-1:0] word_data,
  input  logic                            word_last,
  input  logic                            abort,
  input  logic                            match_release,
  output logic                            match_valid,
  output logic                            match_found,
  output logic [accel_pkg::RULE_ID_W-1:0] rule_id
);
  import accel_pkg::*;

  logic [IO_DATA_W-1:0] rules [RULE_COUNT];
  logic                 word_hit;
  logic [RULE_ID_W-1:0] word_id;
  logic                 acc_found;
  logic [RULE_ID_W-1:0] acc_id;
  logic                 new_found;
  logic [RULE_ID_W-1:0] new_id;

  always_ff @(posedge clk) begin
    if (rule_wr_en) begin
      rules[rule_wr_addr] <= rule_wr_data;
    end
  end

  // Downward scan so the lowest matching index wins
  always_comb begin
    word_hit = 1'b0;
    word_id  = '0;
    for (int i = RULE_COUNT - 1; i >= 0; i--) begin
      if (rules[i] == word_data) begin
        word_hit = 1'b1;
        word_id  = RULE_ID_W'(i);
      end
    end
  end

  // Best hit so far including the current word
  always_comb begin
    new_found = acc_found;
    new_id    = acc_id;
    if (word_valid && word_hit && (!acc_found || (word_id < acc_id))) begin
      new_found = 1'b1;
      new_id    = word_id;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      match_valid <= 1'b0;
      match_found <= 1'b0;
      rule_id     <= '0;
      acc_found   <= 1'b0;
    end else begin
      // Release clears the whole held result
      if (match_release) begin
        match_valid <= 1'b0;
        match_found <= 1'b0;
        rule_id     <= '0;
      end
      if (abort) begin
        acc_found <= 1'b0;
      end else if (word_valid && word_last) begin
        match_valid <= 1'b1;
        match_found <= new_found;
        rule_id     <= new_found ? new_id : '0;
        acc_found   <= 1'b0;
      end else if (word_valid) begin
        acc_found <= new_found;
        acc_id    <= new_id;
      end
    end
  end

endmodule

//--- source/pkt_rd_dma.sv
`timescale 1ns/1ps

module pkt_rd_dma #(
  parameter int MEM_ADDR_W = 10
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            fifo_empty,
  input  logic [MEM_ADDR_W-1:0]           desc_addr,
  input  logic [accel_pkg::LEN_W-1:0]     desc_len,
  input  logic                            hold,
  input  logic                            stop,
  input  logic [accel_pkg::IO_DATA_W-1:0] mem_rd_data,
  output logic                            pop,
  output logic                            mem_en,
  output logic [MEM_ADDR_W-1:0]           mem_addr,
  output logic                            word_valid,
  output logic [accel_pkg::IO_DATA_W-1:0] word_data,
  output logic                            word_last,
  output logic                            abort,
  output logic                            busy
);
  import accel_pkg::*;

  dma_state_e            state;
  logic [LEN_W-1:0]      remaining;
  logic [MEM_ADDR_W-1:0] line_addr;
  logic                  valid_q;
  logic                  last_q;

  // No new packet while the matcher holds a result
  assign pop      = (state == DMA_IDLE) && !fifo_empty && !hold && !stop;
  assign busy     = (state != DMA_IDLE);
  assign mem_en   = (state == DMA_READ);
  assign mem_addr = line_addr;
  assign abort    = stop && busy;

  // Memory answers one cycle after mem_en
  assign word_valid = valid_q;
  assign word_last  = last_q;
  assign word_data  = mem_rd_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= DMA_IDLE;
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      valid_q <= mem_en && !stop;
      last_q  <= mem_en && !stop && (remaining == LEN_W'(1));
      if (stop) begin
        state <= DMA_IDLE;
      end else begin
        case (state)
          DMA_IDLE:  if (pop) state <= DMA_READ;
          DMA_READ:  if (remaining == LEN_W'(1)) state <= DMA_DRAIN;
          DMA_DRAIN: state <= DMA_IDLE;
          default:   state <= DMA_IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      line_addr <= desc_addr;
      remaining <= desc_len;
    end else if (mem_en) begin
      line_addr <= line_addr + 1'b1;
      remaining <= remaining - 1'b1;
    end
  end

endmodule

//--- tests/accel_checker.sv
`timescale 1ns/1ps

module accel_checker (
  input logic clk,
  input logic rst,
  input logic io_en,
  input logic io_wen,
  input logic mem_en,
  input logic io_rd_valid,
  input logic word_valid,
  input logic word_last,
  input logic ip_valid,
  input logic ip_done
);

  a_last_has_valid: assert property (@(posedge clk) disable iff (rst)
    word_last |-> word_valid)
    else $error("word_last raised without word_valid");

  // Outputs settle after the first reset edge
  a_quiet_in_reset: assert property (@(posedge clk)
    (rst && $past(rst)) |-> (!mem_en && !io_rd_valid))
    else $error("mem_en or io_rd_valid active during reset");

  // A new address drops done, which then holds until the next one
  a_done_clears: assert property (@(posedge clk) disable iff (rst)
    ip_valid |=> !ip_done)
    else $error("lookup done while scanning a new address");

  a_done_holds: assert property (@(posedge clk) disable iff (rst)
    (ip_done && !ip_valid) |=> ip_done)
    else $error("lookup done dropped without a new address");

  // Back to back reads may keep valid high
  a_single_rd_valid: assert property (@(posedge clk) disable iff (rst)
    (io_rd_valid && !(io_en && !io_wen)) |=> !io_rd_valid)
    else $error("io_rd_valid high for two cycles");

endmodule

bind accel_top accel_checker chk0 (
  .clk(clk), .rst(rst), .io_en(io_en), .io_wen(io_wen), .mem_en(mem_en),
  .io_rd_valid(io_rd_valid), .word_valid(word_valid), .word_last(word_last),
  .ip_valid(ip_valid), .ip_done(ip_done)
);

//--- tests/accel_golden.txt
# Columns: op a b (hex). W write addr data, E read addr expect, Q 0 expected rule,
# V ctrl mask value poll, C cycles 0 idle, R rule idx data, M mem line, P addr len random
R 0 C0DE0000
R 1 C0DE0001
R 2 C0DE0002
R 3 C0DE0003
R 4 C0DE0004
R 5 C0DE0005
R 6 C0DE0006
R 7 C0DE0007
M 11 C0DE0005
M 13 C0DE0002
P 40 6
T regs
E 00 0
W 04 3
W 08 10
E 04 3
E 08 10
E 20 0
E 3C 0
T match
W 04 4
W 00 1
V 1 1
E 00 3
Q 0 2
W 00 2
T queue
W 08 40
W 04 6
W 00 1
V 1 1
W 08 10
W 04 4
W 00 1
C 14 0
E 00 1
Q 0 0
W 00 2
C 3 0
V 1 1
E 00 3
Q 0 2
W 00 2
T stop
W 08 100
W 04 C8
W 00 1
C 14 0
W 00 4
C 3 0
E 00 0
W 08 10
W 04 4
W 00 1
V 1 1
E 00 3
Q 0 2
W 00 2
T iplookup
W 40 0A000001
W 44 C0A80105
W 48 AC100020
W 4C 08080808
W 10 0501A8C0
E 14 1
W 10 0101A8C0
E 14 0
T fullfifo
W 00 1
V 1 1
W 00 1
W 00 1
W 00 1
W 00 1
W 00 1
E 00 B
W 00 2
C 3 0
V 1 1
E 00 3
W 00 2
C 3 0
V 1 1
E 00 3
W 00 2
C 3 0
V 1 1
E 00 3
W 00 2
C 3 0
V 1 1
E 00 3
W 00 2
C 14 0
E 00 0

//--- tests/accel_tb.sv
`timescale 1ns/1ps

module accel_tb;
  import accel_pkg::*;

  localparam int MEM_ADDR_W = 10;
  localparam int RULE_COUNT = 8;
  localparam int IP_ENTRIES = 4;
  localparam int FIFO_DEPTH = 4;
  localparam int MEM_LINES  = 1 << MEM_ADDR_W;

  logic                          clk;
  logic                          rst;
  logic                          io_en;
  logic                          io_wen;
  logic [IO_ADDR_W-1:0]          io_addr;
  logic [IO_DATA_W-1:0]          io_wr_data;
  logic [IO_DATA_W-1:0]          io_rd_data;
  logic                          io_rd_valid;
  logic                          rule_wr_en;
  logic [$clog2(RULE_COUNT)-1:0] rule_wr_addr;
  logic [IO_DATA_W-1:0]          rule_wr_data;
  logic                          mem_en;
  logic [MEM_ADDR_W-1:0]         mem_addr;
  logic [IO_DATA_W-1:0]          mem_rd_data;
  logic [MEM_ADDR_W-1:0]         mem_line;

  logic [IO_DATA_W-1:0] pkt_mem [MEM_LINES];
  logic [IO_DATA_W-1:0] sw_rules [RULE_COUNT];
  string                kinds[$];
  string                names[$];
  logic [31:0]          arg_a[$];
  logic [31:0]          arg_b[$];
  logic [31:0]          rand_state;
  int                   cycle_count;
  int                   cycle_limit;
  int                   error_count;

  accel_top #(
    .MEM_ADDR_W(MEM_ADDR_W), .RULE_COUNT(RULE_COUNT),
    .IP_ENTRIES(IP_ENTRIES), .FIFO_DEPTH(FIFO_DEPTH)
  ) dut0 (
    .clk(clk), .rst(rst), .io_en(io_en), .io_wen(io_wen), .io_addr(io_addr),
    .io_wr_data(io_wr_data), .io_rd_data(io_rd_data), .io_rd_valid(io_rd_valid),
    .rule_wr_en(rule_wr_en), .rule_wr_addr(rule_wr_addr), .rule_wr_data(rule_wr_data),
    .mem_en(mem_en), .mem_addr(mem_addr), .mem_rd_data(mem_rd_data)
  );

  always #10 clk = ~clk;

  // Packet memory, one cycle read latency
  always @(posedge clk) begin
    if (mem_en) begin
      mem_line = mem_addr;
      #1;
      mem_rd_data = pkt_mem[mem_line];
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: run exceeded %0d cycles", cycle_limit);
      fail_run();
    end
  end

  task automatic fail_run();
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  function automatic logic [31:0] next_random(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic bit hits_rule(logic [IO_DATA_W-1:0] w);
    bit hit;
    hit = 1'b0;
    for (int i = 0; i < RULE_COUNT; i++) begin
      if (sw_rules[i] == w) hit = 1'b1;
    end
    return hit;
  endfunction

  task automatic check_word(string name, logic [IO_DATA_W-1:0] exp, logic [IO_DATA_W-1:0] act);
    if (exp !== act) begin
      error_count++;
      $display("** Error [%s] expected %h, actual %h", name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_rule(string name, logic [RULE_ID_W-1:0] exp, logic [RULE_ID_W-1:0] act);
    if (exp !== act) begin
      error_count++;
      $display("** Error [%s] rule expected %0d, actual %0d", name, exp, act);
      fail_run();
    end
  endtask

  // Each task starts and ends 1 ns after a rising edge
  task automatic host_write(logic [IO_ADDR_W-1:0] a, logic [IO_DATA_W-1:0] d);
    io_en      = 1'b1;
    io_wen     = 1'b1;
    io_addr    = a;
    io_wr_data = d;
    @(posedge clk);
    #1;
    io_en  = 1'b0;
    io_wen = 1'b0;
  endtask

  task automatic host_read(logic [IO_ADDR_W-1:0] a, output logic [IO_DATA_W-1:0] d);
    io_en   = 1'b1;
    io_wen  = 1'b0;
    io_addr = a;
    @(posedge clk);
    #1;
    io_en = 1'b0;
    // Address stays put through a stall
    while (!io_rd_valid) begin
      @(posedge clk);
      #1;
    end
    d = io_rd_data;
  endtask

  task automatic load_rule(logic [31:0] idx, logic [IO_DATA_W-1:0] d);
    rule_wr_en   = 1'b1;
    rule_wr_addr = idx[$clog2(RULE_COUNT)-1:0];
    rule_wr_data = d;
    @(posedge clk);
    #1;
    rule_wr_en = 1'b0;
  endtask

  task automatic wait_ctrl(logic [31:0] mask, logic [31:0] value);
    logic [IO_DATA_W-1:0] d;
    host_read(REG_CTRL, d);
    while ((d & mask) != value) begin
      host_read(REG_CTRL, d);
    end
  endtask

  task automatic read_golden();
    int          fd;
    int          r;
    string       tok;
    string       line;
    string       cur_name;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] w;
    int          cur_len;
    int          lines;
    int          idle;
    fd = $fopen("tests/accel_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open the golden file tests/accel_golden.txt");
      fail_run();
    end
    cur_name = "none";
    cur_len  = 0;
    lines    = 0;
    idle     = 0;
    while (!$feof(fd)) begin
      r = $fscanf(fd, "%s", tok);
      if (r != 1) break;
      if (tok.getc(0) == "#") begin
        r = $fgets(line, fd);
      end else if (tok == "T") begin
        r = $fscanf(fd, "%s", cur_name);
      end else begin
        r = $fscanf(fd, "%h %h", a, b);
        if (r != 2) begin
          $display("Golden file line for op %s is missing its fields", tok);
          fail_run();
        end
        if (tok == "M") begin
          pkt_mem[a[MEM_ADDR_W-1:0]] = b;
        end else if (tok == "P") begin
          // Random words that hit no rule
          for (int i = 0; i < int'(b); i++) begin
            do begin
              rand_state = next_random(rand_state);
              w = rand_state;
            end while (hits_rule(w));
            pkt_mem[a[MEM_ADDR_W-1:0] + i] = w;
          end
        end else begin
          if (tok == "R") sw_rules[a[$clog2(RULE_COUNT)-1:0]] = b;
          if (tok == "W" && a == REG_LEN) cur_len = int'(b);
          if (tok == "W" && a == REG_CTRL && b[CTRL_START]) lines += cur_len;
          if (tok == "C") idle += int'(a);
          kinds.push_back(tok);
          names.push_back(cur_name);
          arg_a.push_back(a);
          arg_b.push_back(b);
        end
      end
    end
    $fclose(fd);
    cycle_limit = 100 + lines + idle + kinds.size() * 20;
  endtask

  initial begin
    logic [IO_DATA_W-1:0] d;
    clk          = 1'b0;
    rst          = 1'b1;
    io_en        = 1'b0;
    io_wen       = 1'b0;
    io_addr      = '0;
    io_wr_data   = '0;
    rule_wr_en   = 1'b0;
    rule_wr_addr = '0;
    rule_wr_data = '0;
    mem_rd_data  = '0;
    cycle_count  = 0;
    cycle_limit  = 1000;
    error_count  = 0;
    rand_state   = 32'd89016;
    for (int i = 0; i < MEM_LINES; i++) begin
      pkt_mem[i] = {6'h2A, i[9:0], 6'h15, i[9:0]};
    end
    read_golden();
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int k = 0; k < kinds.size(); k++) begin
      case (kinds[k])
        "R": load_rule(arg_a[k], arg_b[k]);
        "W": host_write(arg_a[k][IO_ADDR_W-1:0], arg_b[k]);
        "E": begin
          host_read(arg_a[k][IO_ADDR_W-1:0], d);
          check_word(names[k], arg_b[k], d);
        end
        "Q": begin
          host_read(REG_RULE, d);
          check_rule(names[k], arg_b[k][RULE_ID_W-1:0], d[RULE_ID_W-1:0]);
        end
        "V": wait_ctrl(arg_a[k], arg_b[k]);
        "C": repeat (arg_a[k]) begin
          @(posedge clk);
          #1;
        end
        default: begin
          $display("Unknown golden operation %s in test %s", kinds[k], names[k]);
          fail_run();
        end
      endcase
    end
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      fail_run();
    end
  end

endmodule
